/* tests/decode_trace.txt */
# W addr data : one writeback strobe (hex)
# D pc insn then expected opcode rs rt rd sa func alu_op imm_sx target illegal rs_data rt_data
# R-type, including MUL
D 00400000 00221820 00 01 02 03 00 20 20 00000000 0000000 0 00000001 00000002
D 00400004 00853022 00 04 05 06 00 22 22 00000000 0000000 0 00000004 00000005
D 00400008 00e84826 00 07 08 09 00 26 26 00000000 0000000 0 00000007 00000008
D 0040000c 014b60e1 00 0a 0b 0c 00 21 21 00000000 0000000 0 0000000a 0000000b
D 00400010 00432818 00 02 03 00 00 18 18 00000000 0000000 0 00000002 00000003
D 00400014 018d001b 00 0c 0d 00 00 1b 1b 00000000 0000000 0 0000000c 0000000d
D 00400018 00227010 00 00 00 0e 00 10 10 00000000 0000000 0 00000000 00000000
D 0040001c 00007812 00 00 00 0f 00 12 12 00000000 0000000 0 00000000 00000000
D 00400020 00708900 00 00 10 11 04 00 00 00000000 0000000 0 00000000 00000010
D 00400024 00129fc3 00 00 12 13 1f 03 03 00000000 0000000 0 00000000 00000012
D 00400028 0295b086 00 14 15 16 00 06 06 00000000 0000000 0 00000014 00000015
D 0040002c 03e11008 00 1f 00 00 00 08 08 00000000 0000000 0 0000001f 00000000
D 00400030 70a63802 1c 05 06 07 00 02 02 00000000 0000000 0 00000005 00000006
# I-type, J-type and NOP
D 00400034 2022fffc 08 01 02 00 00 00 08 fffffffc 0000000 0 00000001 00000002
D 00400038 34641234 0d 03 04 00 00 00 0d 00001234 0000000 0 00000003 00000004
D 0040003c 8fa88000 23 1d 08 00 00 00 23 ffff8000 0000000 0 0000001d 00000008
D 00400040 152a7fff 05 09 0a 00 00 00 05 00007fff 0000000 0 00000009 0000000a
D 00400044 3ccbabcd 0f 00 0b 00 00 00 0f ffffabcd 0000000 0 00000000 0000000b
D 00400048 08100010 02 00 00 00 00 00 02 00000000 0100010 0 00000000 00000000
D 0040004c 0fffffff 03 00 00 00 00 00 03 00000000 3ffffff 0 00000000 00000000
D 00400050 00000000 00 00 00 00 00 00 00 00000000 0000000 0 00000000 00000000
# Illegal opcode and function codes, then writeback
D 00400054 fc221820 00 00 00 00 00 00 00 00000000 0000000 1 00000000 00000000
D 00400058 00221801 00 00 00 00 00 00 00 00000000 0000000 1 00000000 00000000
D 0040005c 70a63800 00 00 00 00 00 00 00 00000000 0000000 1 00000000 00000000
W 05 deadbeef
W 06 12345678
D 00400060 00a60820 00 05 06 01 00 20 20 00000000 0000000 0 deadbeef 12345678
W 00 cafef00d
W 1f 0badc0de
D 00400064 001f1026 00 00 1f 02 00 26 26 00000000 0000000 0 cafef00d 0badc0de

/* all.f */
+incdir+include
design/decode_pkg.sv
design/insn_classifier.sv
design/decode_register.sv
design/reg_file.sv
design/decode_stage.sv
tests/decode_assert.sv
tests/decode_tb.sv

/* Makefile */
TOP := decode_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "Test failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "Run ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tests/decode_tb.sv */
module decode_tb;
	import decode_pkg::*;

	localparam int MAX_CYCLES = 1000; // Reset plus ~35 records of up to 12 cycles

	logic      clock;
	logic      arst_n;
	logic      insn_req;
	logic      insn_ack;
	word_t     insn;
	word_t     pc;
	opcode_e   opcode;
	reg_addr_t rs, rt, rd;
	shamt_t    sa;
	func_t     func;
	alu_op_t   alu_op;
	word_t     imm_sx;
	target_t   target;
	logic      illegal;
	word_t     pc_out, insn_out;
	word_t     rs_data, rt_data;
	logic      wb_en;
	reg_addr_t wb_addr;
	word_t     wb_data;

	// Current trace record
	word_t     exp_pc, exp_insn;
	alu_op_t   exp_opcode, exp_alu_op;
	reg_addr_t exp_rs, exp_rt, exp_rd;
	shamt_t    exp_sa;
	func_t     exp_func;
	word_t     exp_imm_sx;
	target_t   exp_target;
	logic      exp_illegal;
	word_t     exp_rs_data, exp_rt_data;
	reg_addr_t w_addr;
	word_t     w_data;

	int            fd;
	int            code;
	int            n_decodes;
	int            cycle_count = 0;
	logic [7:0]    tag;
	logic [1023:0] skip_line;

	decode_stage i_dut (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			abort_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_opcode(input string name, input opcode_e got, input opcode_e exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_small(input string name, input alu_op_t got, input alu_op_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp));
	endtask

	task automatic write_reg(input reg_addr_t addr, input word_t data);
		@(negedge clock);
		wb_en = 1'b1;
		wb_addr = addr;
		wb_data = data;
		@(negedge clock);
		wb_en = 1'b0;
	endtask

	task automatic check_outputs();
		check_opcode("opcode", opcode, opcode_e'(exp_opcode));
		check_addr("rs", rs, exp_rs);
		check_addr("rt", rt, exp_rt);
		check_addr("rd", rd, exp_rd);
		check_small("sa", alu_op_t'(sa), alu_op_t'(exp_sa));
		check_small("func", alu_op_t'(func), alu_op_t'(exp_func));
		check_small("alu_op", alu_op, exp_alu_op);
		check_word("imm_sx", imm_sx, exp_imm_sx);
		check_word("target", word_t'(target), word_t'(exp_target));
		check_flag("illegal", illegal, exp_illegal);
		check_word("pc_out", pc_out, exp_pc);
		check_word("insn_out", insn_out, exp_insn);
		check_word("rs_data", rs_data, exp_rs_data);
		check_word("rt_data", rt_data, exp_rt_data);
	endtask

	// One four-phase transaction
	task automatic run_decode();
		@(negedge clock);
		pc = exp_pc;
		insn = exp_insn;
		insn_req = 1'b1;
		while (!insn_ack) @(negedge clock);
		check_outputs(); // Outputs settled since the capture edge
		insn_req = 1'b0;
		while (insn_ack) @(negedge clock);
		n_decodes++;
	endtask

	initial begin
		arst_n = 1'b0;
		insn_req = 1'b0;
		insn = '0;
		pc = '0;
		wb_en = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		n_decodes = 0;
		repeat (10) @(negedge clock);
		arst_n = 1'b1;
		check_flag("insn_ack after reset", insn_ack, 1'b0);
		fd = $fopen("tests/decode_trace.txt", "r");
		if (fd == 0)
			abort_run("Could not open tests/decode_trace.txt");
		while ($fscanf(fd, " %c", tag) == 1) begin
			case (tag)
				"#": code = $fgets(skip_line, fd);
				"W": begin
					code = $fscanf(fd, "%h %h", w_addr, w_data);
					if (code != 2)
						abort_run("A writeback record in the trace file is incomplete");
					write_reg(w_addr, w_data);
				end
				"D": begin
					code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						exp_pc, exp_insn, exp_opcode, exp_rs, exp_rt, exp_rd, exp_sa, exp_func,
						exp_alu_op, exp_imm_sx, exp_target, exp_illegal, exp_rs_data, exp_rt_data);
					if (code != 14)
						abort_run("A decode record in the trace file is incomplete");
					run_decode();
				end
				default: abort_run($sformatf("Unknown record type '%c' in trace file", tag));
			endcase
		end
		$fclose(fd);
		if (n_decodes == 0) begin
			abort_run("The trace file held no decode records");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

/* tests/decode_assert.sv */
module decode_assert (
	input logic                  clock,
	input logic                  arst_n,
	input logic                  insn_req,
	input logic                  insn_ack,
	input decode_pkg::opcode_e   opcode,
	input decode_pkg::reg_addr_t rs,
	input decode_pkg::reg_addr_t rt,
	input decode_pkg::reg_addr_t rd,
	input decode_pkg::shamt_t    sa,
	input decode_pkg::func_t     func,
	input decode_pkg::alu_op_t   alu_op,
	input decode_pkg::word_t     imm_sx,
	input decode_pkg::target_t   target,
	input logic                  illegal,
	input decode_pkg::word_t     pc_out,
	input decode_pkg::word_t     insn_out
);

	ack_low_in_reset: assert property (@(posedge clock) !arst_n |-> !insn_ack)
		else $error("insn_ack high during reset");

	ack_rise_needs_req: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(insn_ack) |-> $past(insn_req))
		else $error("insn_ack rose without a pending insn_req");

	ack_held_with_req: assert property (@(posedge clock) disable iff (!arst_n)
		insn_ack && insn_req |=> insn_ack)
		else $error("insn_ack dropped while insn_req was still high");

	// No capture can happen in HOLD
	outputs_stable: assert property (@(posedge clock) disable iff (!arst_n)
		insn_ack |=> $stable({opcode, rs, rt, rd, sa, func, alu_op, imm_sx, target, illegal,
			pc_out, insn_out}))
		else $error("decoded outputs changed while insn_ack was high");

endmodule

bind decode_register decode_assert i_decode_assert (.*);

/* design/decode_stage.sv */
module decode_stage (
	input  logic                  clock,
	input  logic                  arst_n,
	input  decode_pkg::word_t     insn,
	input  decode_pkg::word_t     pc,
	input  logic                  insn_req,
	output logic                  insn_ack,
	output decode_pkg::opcode_e   opcode,
	output decode_pkg::reg_addr_t rs,
	output decode_pkg::reg_addr_t rt,
	output decode_pkg::reg_addr_t rd,
	output decode_pkg::shamt_t    sa,
	output decode_pkg::func_t     func,
	output decode_pkg::alu_op_t   alu_op,
	output decode_pkg::word_t     imm_sx,
	output decode_pkg::target_t   target,
	output logic                  illegal,
	output decode_pkg::word_t     pc_out,
	output decode_pkg::word_t     insn_out,
	output decode_pkg::word_t     rs_data,
	output decode_pkg::word_t     rt_data,
	input  logic                  wb_en,
	input  decode_pkg::reg_addr_t wb_addr,
	input  decode_pkg::word_t     wb_data
);
	import decode_pkg::*;

	opcode_e   cls_opcode;
	reg_addr_t cls_rs;
	reg_addr_t cls_rt;
	reg_addr_t cls_rd;
	shamt_t    cls_sa;
	func_t     cls_func;
	alu_op_t   cls_alu_op;
	word_t     cls_imm_sx;
	target_t   cls_target;
	logic      cls_illegal;

	insn_classifier i_classifier (
		.insn    (insn),
		.opcode  (cls_opcode),
		.rs      (cls_rs),
		.rt      (cls_rt),
		.rd      (cls_rd),
		.sa      (cls_sa),
		.func    (cls_func),
		.alu_op  (cls_alu_op),
		.imm_sx  (cls_imm_sx),
		.target  (cls_target),
		.illegal (cls_illegal)
	);

	decode_register i_decode_register (
		.clock       (clock),
		.arst_n      (arst_n),
		.insn_req    (insn_req),
		.insn_ack    (insn_ack),
		.insn        (insn),
		.pc          (pc),
		.cls_opcode  (cls_opcode),
		.cls_rs      (cls_rs),
		.cls_rt      (cls_rt),
		.cls_rd      (cls_rd),
		.cls_sa      (cls_sa),
		.cls_func    (cls_func),
		.cls_alu_op  (cls_alu_op),
		.cls_imm_sx  (cls_imm_sx),
		.cls_target  (cls_target),
		.cls_illegal (cls_illegal),
		.opcode      (opcode),
		.rs          (rs),
		.rt          (rt),
		.rd          (rd),
		.sa          (sa),
		.func        (func),
		.alu_op      (alu_op),
		.imm_sx      (imm_sx),
		.target      (target),
		.illegal     (illegal),
		.pc_out      (pc_out),
		.insn_out    (insn_out)
	);

	// Read ports follow the captured source indices
	reg_file i_reg_file (
		.clock   (clock),
		.arst_n  (arst_n),
		.rs_addr (rs),
		.rt_addr (rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wb_en   (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

endmodule

/* design/reg_file.sv */
`include "decode_config.svh"

module reg_file (
	input  logic                  clock,
	input  logic                  arst_n,
	input  decode_pkg::reg_addr_t rs_addr,
	input  decode_pkg::reg_addr_t rt_addr,
	output decode_pkg::word_t     rs_data,
	output decode_pkg::word_t     rt_data,
	input  logic                  wb_en,
	input  decode_pkg::reg_addr_t wb_addr,
	input  decode_pkg::word_t     wb_data
);
	import decode_pkg::*;

	word_t regs [`DECODE_NUM_REGS];

	// Register 0 is writable like any other
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `DECODE_NUM_REGS; i++) begin
				regs[i] <= word_t'(i); // Register n starts at n
			end
		end else if (wb_en) begin
			regs[wb_addr] <= wb_data;
		end
	end

	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

endmodule

/* design/decode_register.sv */
module decode_register (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  insn_req,
	output logic                  insn_ack,
	input  decode_pkg::word_t     insn,
	input  decode_pkg::word_t     pc,
	input  decode_pkg::opcode_e   cls_opcode,
	input  decode_pkg::reg_addr_t cls_rs,
	input  decode_pkg::reg_addr_t cls_rt,
	input  decode_pkg::reg_addr_t cls_rd,
	input  decode_pkg::shamt_t    cls_sa,
	input  decode_pkg::func_t     cls_func,
	input  decode_pkg::alu_op_t   cls_alu_op,
	input  decode_pkg::word_t     cls_imm_sx,
	input  decode_pkg::target_t   cls_target,
	input  logic                  cls_illegal,
	output decode_pkg::opcode_e   opcode,
	output decode_pkg::reg_addr_t rs,
	output decode_pkg::reg_addr_t rt,
	output decode_pkg::reg_addr_t rd,
	output decode_pkg::shamt_t    sa,
	output decode_pkg::func_t     func,
	output decode_pkg::alu_op_t   alu_op,
	output decode_pkg::word_t     imm_sx,
	output decode_pkg::target_t   target,
	output logic                  illegal,
	output decode_pkg::word_t     pc_out,
	output decode_pkg::word_t     insn_out
);
	import decode_pkg::*;

	hs_state_e state;
	logic      capture;

	assign capture  = (state == IDLE) && insn_req;
	assign insn_ack = (state == HOLD);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (insn_req) state <= HOLD;
				HOLD: if (!insn_req) state <= IDLE; // Four-phase release
				default: state <= IDLE;
			endcase
		end
	end

	// Outputs hold from capture until the next request
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			opcode   <= RTYPE;
			rs       <= '0;
			rt       <= '0;
			rd       <= '0;
			sa       <= '0;
			func     <= '0;
			alu_op   <= '0;
			imm_sx   <= '0;
			target   <= '0;
			illegal  <= 1'b0;
			pc_out   <= '0;
			insn_out <= '0;
		end else if (capture) begin
			opcode   <= cls_opcode;
			rs       <= cls_rs;
			rt       <= cls_rt;
			rd       <= cls_rd;
			sa       <= cls_sa;
			func     <= cls_func;
			alu_op   <= cls_alu_op;
			imm_sx   <= cls_imm_sx;
			target   <= cls_target;
			illegal  <= cls_illegal;
			pc_out   <= pc;
			insn_out <= insn;
		end
	end

endmodule

/* design/insn_classifier.sv */
`include "decode_config.svh"

module insn_classifier (
	input  decode_pkg::word_t     insn,
	output decode_pkg::opcode_e   opcode,
	output decode_pkg::reg_addr_t rs,
	output decode_pkg::reg_addr_t rt,
	output decode_pkg::reg_addr_t rd,
	output decode_pkg::shamt_t    sa,
	output decode_pkg::func_t     func,
	output decode_pkg::alu_op_t   alu_op,
	output decode_pkg::word_t     imm_sx,
	output decode_pkg::target_t   target,
	output logic                  illegal
);
	import decode_pkg::*;

	alu_op_t   op_f;
	func_t     fn_f;
	reg_addr_t rs_f;
	reg_addr_t rt_f;
	reg_addr_t rd_f;
	shamt_t    sa_f;
	imm_t      imm_f;
	target_t   target_f;

	logic known; // Opcode and func both listed
	logic is_r;
	logic use_rs;
	logic use_rt;
	logic use_rd;
	logic use_sa;
	logic use_imm;
	logic use_target;

	assign op_f     = insn[`DECODE_WORD_W-1 -: `DECODE_OPCODE_W];
	assign rs_f     = insn[25:21];
	assign rt_f     = insn[20:16];
	assign rd_f     = insn[15:11];
	assign sa_f     = insn[10:6];
	assign fn_f     = insn[`DECODE_FUNC_W-1:0];
	assign imm_f    = insn[`DECODE_IMM_W-1:0];
	assign target_f = insn[`DECODE_TARGET_W-1:0];

	always_comb begin
		known = 1'b1;
		is_r = 1'b0;
		use_rs = 1'b0;
		use_rt = 1'b0;
		use_rd = 1'b0;
		use_sa = 1'b0;
		use_imm = 1'b0;
		use_target = 1'b0;
		case (op_f)
			RTYPE: begin
				is_r = 1'b1;
				case (fn_f)
					ADD, ADDU, SUB, SUBU, SLT, SLTU, SLLV, SRLV, SRAV,
					AND, OR, XOR, NOR, JALR: begin
						use_rs = 1'b1;
						use_rt = 1'b1;
						use_rd = 1'b1;
					end
					MULT, MULTU, DIV, DIVU: begin // Result goes to HI/LO
						use_rs = 1'b1;
						use_rt = 1'b1;
					end
					MFHI, MFLO: use_rd = 1'b1;
					SLL, SRL, SRA: begin // All-zero NOP lands here as SLL
						use_rt = 1'b1;
						use_rd = 1'b1;
						use_sa = 1'b1;
					end
					JR: use_rs = 1'b1;
					default: known = 1'b0;
				endcase
			end
			MUL_OP: begin
				is_r = 1'b1;
				if (fn_f == MUL_FUNC) begin
					use_rs = 1'b1;
					use_rt = 1'b1;
					use_rd = 1'b1;
				end else begin
					known = 1'b0;
				end
			end
			LUI: begin
				use_rt = 1'b1;
				use_imm = 1'b1;
			end
			ADDI, ADDIU, SLTI, SLTIU, ORI, XORI, LW, SW, LB, SB, LBU,
			BEQ, BNE, BGTZ: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				use_imm = 1'b1;
			end
			J, JAL: use_target = 1'b1;
			default: known = 1'b0;
		endcase
	end

	assign opcode  = known ? opcode_e'(op_f) : RTYPE;
	assign rs      = (known && use_rs) ? rs_f : '0;
	assign rt      = (known && use_rt) ? rt_f : '0;
	assign rd      = (known && use_rd) ? rd_f : '0;
	assign sa      = (known && use_sa) ? sa_f : '0;
	assign func    = (known && is_r) ? fn_f : '0;
	assign alu_op  = !known ? '0 : (is_r ? fn_f : op_f);
	assign imm_sx  = (known && use_imm) ?
		{{(`DECODE_WORD_W-`DECODE_IMM_W){imm_f[`DECODE_IMM_W-1]}}, imm_f} : '0;
	assign target  = (known && use_target) ? target_f : '0;
	assign illegal = !known;

endmodule

/* design/decode_pkg.sv */
`include "decode_config.svh"

package decode_pkg;

	typedef logic [`DECODE_WORD_W-1:0] word_t;
	typedef logic [`DECODE_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`DECODE_SHAMT_W-1:0] shamt_t;
	typedef logic [`DECODE_FUNC_W-1:0] func_t;
	typedef logic [`DECODE_OPCODE_W-1:0] alu_op_t; // Func for R-type, opcode otherwise
	typedef logic [`DECODE_IMM_W-1:0] imm_t;
	typedef logic [`DECODE_TARGET_W-1:0] target_t;

	typedef enum logic [`DECODE_OPCODE_W-1:0] {
		RTYPE  = 6'b000000, // Also the NOP opcode
		MUL_OP = 6'b011100,
		ADDI   = 6'b001000, ADDIU = 6'b001001, SLTI = 6'b001010, SLTIU = 6'b001011,
		ORI    = 6'b001101, XORI  = 6'b001110, LUI  = 6'b001111,
		LW     = 6'b100011, SW    = 6'b101011, LB   = 6'b100000, SB    = 6'b101000,
		LBU    = 6'b100100,
		BEQ    = 6'b000100, BNE   = 6'b000101, BGTZ = 6'b000111,
		J      = 6'b000010, JAL   = 6'b000011
	} opcode_e;

	typedef enum logic [`DECODE_FUNC_W-1:0] {
		ADD  = 6'b100000, ADDU  = 6'b100001, SUB  = 6'b100010, SUBU = 6'b100011,
		MULT = 6'b011000, MULTU = 6'b011001, DIV  = 6'b011010, DIVU = 6'b011011,
		MFHI = 6'b010000, MFLO  = 6'b010010,
		SLT  = 6'b101010, SLTU  = 6'b101011,
		SLL  = 6'b000000, SLLV  = 6'b000100, SRL  = 6'b000010, SRLV = 6'b000110,
		SRA  = 6'b000011, SRAV  = 6'b000111,
		AND  = 6'b100100, OR    = 6'b100101, XOR  = 6'b100110, NOR  = 6'b100111,
		JALR = 6'b001001, JR    = 6'b001000
	} rfunc_e;

	// MUL shares its function code with SRL, only the opcode tells them apart
	localparam rfunc_e MUL_FUNC = SRL;

	typedef enum logic {
		IDLE,
		HOLD
	} hs_state_e;

endpackage

/* include/decode_config.svh */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Datapath and instruction word
`define DECODE_WORD_W 32

// Register file geometry
`define DECODE_REG_ADDR_W 5
`define DECODE_NUM_REGS 32

// Instruction field widths
`define DECODE_OPCODE_W 6
`define DECODE_FUNC_W 6
`define DECODE_SHAMT_W 5
`define DECODE_IMM_W 16
`define DECODE_TARGET_W 26

`endif
